// File: include/tetris_cfg.svh
`ifndef TETRIS_CFG_SVH
`define TETRIS_CFG_SVH

// board size in cells
`define BOARD_ROWS 20
`define BOARD_COLS 10

// frame ticks per countdown digit
`define COUNT_FRAMES 40

// frame ticks per gravity step at level 0
`define START_SPEED 10

`endif

// File: source/tetris_pkg.sv
`include "tetris_cfg.svh"

package tetris_pkg;

	typedef enum logic [2:0] {
		st_idle,
		st_count,
		st_spawn,
		st_fall,
		st_clear,
		st_fail,
		st_clean
	} game_state_e;

	// 0 is left free, means no piece loaded
	typedef enum logic [2:0] {
		pk_t = 3'd1,
		pk_o = 3'd2,
		pk_l = 3'd3,
		pk_j = 3'd4,
		pk_s = 3'd5,
		pk_z = 3'd6,
		pk_i = 3'd7
	} piece_kind_e;

	typedef struct packed {
		logic [4:0] row;
		logic [3:0] col;
	} cell_t;

	typedef cell_t [3:0] piece_t;

	typedef logic [`BOARD_COLS-1:0] row_bits_t;

endpackage

// File: source/piece_if.sv
`timescale 1ns/1ps

interface piece_if import tetris_pkg::*; ();

	piece_t      cells;      // active piece
	piece_kind_e kind;
	logic        spawn;
	logic        move_left;
	logic        move_right;
	logic        move_down;
	logic        restore;    // backup -> active
	logic        save;       // active -> backup

	modport unit (
		output cells, kind,
		input  spawn, move_left, move_right, move_down, restore, save
	);

	modport ctrl (
		output spawn, move_left, move_right, move_down, restore, save,
		input  kind
	);

	modport board (
		input  cells
	);

endinterface

// File: source/game_fsm.sv
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module game_fsm import tetris_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        frame_tick,
	input  logic        key_left,
	input  logic        key_right,
	input  logic        key_drop,
	input  logic        hit,
	input  logic        count_done,
	input  logic        fall_due,
	input  logic        clear_done,
	piece_if.ctrl       pif,
	output game_state_e state,
	output logic        count_start,
	output logic        fall_start,
	output logic        lock,
	output logic        clear_rows,
	output logic        clean_row,
	output logic [4:0]  clean_index
);

	logic [2:0] keys;
	logic [2:0] keys_q;
	logic [2:0] rise;
	logic       press;
	logic       left_req;
	logic       right_req;
	logic       descend;
	logic [2:0] step;   // falling sequence position

	assign keys      = {key_drop, key_right, key_left};
	assign rise      = keys & ~keys_q;
	assign press     = |rise;
	assign descend   = fall_due || key_drop;
	assign clean_row = state == st_clean;

	// ====================
	// state and step
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= st_idle;
			step        <= 3'd0;
			keys_q      <= 3'd0;
			left_req    <= 1'b0;
			right_req   <= 1'b0;
			clean_index <= 5'd0;
		end else begin
			keys_q <= keys;
			case (state)
				st_idle: if (press) state <= st_count;
				st_count: begin
					if (count_done) begin
						state <= st_spawn;
						step  <= 3'd0;
					end
				end
				st_spawn: begin
					if (step == 3'd0)
						step <= 3'd1;
					else if (pif.kind != piece_kind_e'(3'd0)) begin   // piece loaded
						state <= hit ? st_fail : st_fall;
						step  <= 3'd0;
					end
				end
				st_fall: begin
					left_req  <= left_req || rise[0];
					right_req <= right_req || rise[1];
					case (step)
						3'd0: if (frame_tick) step <= 3'd1;
						3'd1: begin
							left_req  <= rise[0];   // request consumed
							right_req <= rise[1];
							step      <= 3'd2;
						end
						3'd3: step <= descend ? 3'd4 : 3'd0;
						3'd4: step <= hit ? 3'd5 : 3'd0;
						3'd6: begin
							state     <= st_clear;
							step      <= 3'd0;
							left_req  <= 1'b0;
							right_req <= 1'b0;
						end
						default: step <= step + 3'd1;
					endcase
				end
				st_clear: if (clear_done) state <= st_spawn;
				st_fail: begin
					if (press) begin
						state       <= st_clean;
						clean_index <= 5'd0;
					end
				end
				st_clean: begin
					if (clean_index == 5'(`BOARD_ROWS - 1))
						state <= st_idle;
					else
						clean_index <= clean_index + 5'd1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// ====================
	// strobes
	// ====================
	always_comb begin
		pif.spawn      = 1'b0;
		pif.move_left  = 1'b0;
		pif.move_right = 1'b0;
		pif.move_down  = 1'b0;
		pif.restore    = 1'b0;
		pif.save       = 1'b0;
		count_start    = 1'b0;
		fall_start     = 1'b0;
		lock           = 1'b0;
		clear_rows     = 1'b0;
		case (state)
			st_idle: count_start = press;
			st_spawn: begin
				pif.spawn  = step == 3'd0;
				fall_start = step != 3'd0 && !hit;   // fresh gravity count
			end
			st_fall: begin
				case (step)
					3'd0: pif.save = frame_tick;
					3'd1: begin
						pif.move_left  = left_req;
						pif.move_right = right_req && !left_req;
					end
					3'd2: begin
						pif.restore = hit;   // blocked move
						pif.save    = !hit;
					end
					3'd3: begin
						pif.move_down = descend;
						fall_start    = descend;
					end
					3'd4: pif.restore = hit;   // landed
					3'd5: lock = 1'b1;
					3'd6: clear_rows = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

// File: source/frame_timer.sv
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module frame_timer (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       frame_tick,
	input  logic       count_start,
	input  logic       fall_start,
	input  logic       level_up,
	output logic [1:0] countdown,
	output logic       count_done,
	output logic       fall_due
);

	localparam int TICK_W  = $clog2(`COUNT_FRAMES);
	localparam int SPEED_W = $clog2(`START_SPEED + 1);

	logic               counting;
	logic               digit_end;
	logic [TICK_W-1:0]  tick_cnt;
	logic [SPEED_W-1:0] speed;      // frames per row
	logic [SPEED_W-1:0] fall_cnt;

	assign digit_end  = counting && frame_tick && tick_cnt == TICK_W'(`COUNT_FRAMES - 1);
	assign count_done = digit_end && countdown == 2'd0;
	assign fall_due   = fall_cnt >= speed;

	// countdown 3..0
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			counting  <= 1'b0;
			tick_cnt  <= '0;
			countdown <= 2'd0;
		end else if (count_start) begin
			counting  <= 1'b1;
			tick_cnt  <= '0;
			countdown <= 2'd3;
		end else if (digit_end) begin
			tick_cnt <= '0;
			if (countdown == 2'd0)
				counting <= 1'b0;
			else
				countdown <= countdown - 2'd1;
		end else if (counting && frame_tick) begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// gravity
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			speed    <= SPEED_W'(`START_SPEED);
			fall_cnt <= '0;
		end else begin
			if (count_start)
				speed <= SPEED_W'(`START_SPEED);
			else if (level_up && speed != '0)
				speed <= speed - 1'b1;   // floor at 0, every frame
			if (fall_start)
				fall_cnt <= '0;
			else if (frame_tick && fall_cnt < speed)
				fall_cnt <= fall_cnt + 1'b1;
		end
	end

endmodule

// File: source/piece_unit.sv
`timescale 1ns/1ps

module piece_unit import tetris_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	piece_if.unit       pif,
	output piece_kind_e next_kind
);

	logic [6:0] lfsr;
	piece_t     moved;
	piece_t     backup;

	function automatic cell_t cell_at(input int row, input int col);
		cell_t c;
		c.row = 5'(row);
		c.col = 4'(col);
		return c;
	endfunction

	// spawn layouts, rows 0..1 and columns 2..5
	function automatic piece_t spawn_shape(input piece_kind_e kind);
		piece_t p;
		case (kind)
			pk_t:    p = {cell_at(1, 5), cell_at(1, 4), cell_at(1, 3), cell_at(0, 4)};
			pk_o:    p = {cell_at(0, 4), cell_at(1, 4), cell_at(1, 3), cell_at(0, 3)};
			pk_l:    p = {cell_at(1, 5), cell_at(1, 4), cell_at(1, 3), cell_at(0, 5)};
			pk_j:    p = {cell_at(1, 5), cell_at(1, 4), cell_at(1, 3), cell_at(0, 3)};
			pk_s:    p = {cell_at(0, 5), cell_at(1, 4), cell_at(1, 3), cell_at(0, 4)};
			pk_z:    p = {cell_at(1, 5), cell_at(0, 4), cell_at(0, 3), cell_at(1, 4)};
			pk_i:    p = {cell_at(1, 5), cell_at(1, 4), cell_at(1, 3), cell_at(1, 2)};
			default: p = '0;
		endcase
		return p;
	endfunction

	// lfsr never holds 0, mod 7 plus one gives codes 1..7
	assign next_kind = piece_kind_e'(3'(lfsr % 7) + 3'd1);

	always_comb begin
		moved = pif.cells;
		for (int i = 0; i < 4; i++) begin
			if (pif.move_left)
				moved[i].col = pif.cells[i].col - 4'd1;   // col 0 wraps to 15, caught as hit
			else if (pif.move_right)
				moved[i].col = pif.cells[i].col + 4'd1;
			else if (pif.move_down)
				moved[i].row = pif.cells[i].row + 5'd1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lfsr      <= 7'h01;
			pif.kind  <= piece_kind_e'(3'd0);
			pif.cells <= '0;
		end else begin
			lfsr <= {lfsr[5:0], lfsr[6] ^ lfsr[5]};   // x^7 + x^6 + 1
			if (pif.spawn) begin
				pif.kind  <= next_kind;
				pif.cells <= spawn_shape(next_kind);
			end else if (pif.restore) begin
				pif.cells <= backup;
			end else begin
				pif.cells <= moved;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pif.save)
			backup <= pif.cells;
	end

endmodule

// File: source/board_mem.sv
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module board_mem import tetris_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       lock,
	input  logic       clear_rows,
	input  logic       clean_row,
	input  logic [4:0] clean_index,
	input  logic       count_start,
	input  logic [4:0] board_row_sel,
	piece_if.board     pif,
	output logic       hit,
	output logic       clear_done,
	output logic       level_up,
	output row_bits_t  board_row,
	output logic [9:0] lines,
	output logic [5:0] level
);

	row_bits_t              board [`BOARD_ROWS];
	logic [`BOARD_ROWS-1:0] full_mask;   // full rows under the piece
	logic [2:0]             n_full;
	logic [2:0]             clear_cnt;

	// ====================
	// collision and full rows
	// ====================
	always_comb begin
		hit       = 1'b0;
		full_mask = '0;
		for (int i = 0; i < 4; i++) begin
			if (pif.cells[i].col >= 4'(`BOARD_COLS) || pif.cells[i].row >= 5'(`BOARD_ROWS)) begin
				hit = 1'b1;
			end else begin
				if (board[pif.cells[i].row][pif.cells[i].col])
					hit = 1'b1;
				if (&board[pif.cells[i].row])
					full_mask[pif.cells[i].row] = 1'b1;
			end
		end
	end

	assign n_full   = 3'($countones(full_mask));
	assign level_up = clear_done && clear_cnt == 3'd4;

	// ====================
	// board and counters
	// ====================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < `BOARD_ROWS; r++)
				board[r] <= '0;
			lines      <= 10'd0;
			level      <= 6'd0;
			clear_cnt  <= 3'd0;
			clear_done <= 1'b0;
		end else begin
			clear_done <= clear_rows;
			if (lock) begin
				for (int i = 0; i < 4; i++)
					board[pif.cells[i].row][pif.cells[i].col] <= 1'b1;
			end
			if (clear_rows) begin
				for (int r = 0; r < `BOARD_ROWS; r++)
					if (full_mask[r])
						board[r] <= '0;   // zeroed in place, no collapse
				lines     <= lines + 10'(n_full);
				clear_cnt <= n_full;
			end
			if (clean_row)
				board[clean_index] <= '0;
			if (count_start) begin
				lines <= 10'd0;
				level <= 6'd0;
			end else if (level_up) begin
				level <= level + 6'd1;
			end
		end
	end

	// read port, one cycle late
	always_ff @(posedge clk) begin
		if (board_row_sel < 5'(`BOARD_ROWS))
			board_row <= board[board_row_sel];
		else
			board_row <= '0;
	end

endmodule

// File: source/tetris_top.sv
`timescale 1ns/1ps

module tetris_top import tetris_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        frame_tick,
	input  logic        key_left,
	input  logic        key_right,
	input  logic        key_drop,
	input  logic [4:0]  board_row_sel,
	output game_state_e state,
	output logic [1:0]  countdown,
	output piece_t      piece,
	output piece_kind_e next_kind,
	output row_bits_t   board_row,
	output logic [9:0]  lines,
	output logic [5:0]  level
);

	// fsm <-> board
	logic       hit;
	logic       lock;
	logic       clear_rows;
	logic       clear_done;
	logic       clean_row;
	logic [4:0] clean_index;

	// fsm <-> timer
	logic       count_start;
	logic       count_done;
	logic       fall_start;
	logic       fall_due;
	logic       level_up;

	piece_if pif ();

	assign piece = pif.cells;

	game_fsm u_game_fsm (.*);

	frame_timer u_frame_timer (.*);

	piece_unit u_piece_unit (.*);

	board_mem u_board_mem (.*);

endmodule

// File: sim/tetris_tb_sva.sv
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module tetris_tb_sva import tetris_pkg::*; (
	input logic        clk,
	input logic        arst_n,
	input game_state_e state,
	input logic [1:0]  countdown,
	input piece_t      piece,
	input logic [9:0]  lines
);

	logic in_board;

	always_comb begin
		in_board = 1'b1;
		for (int i = 0; i < 4; i++)
			if (piece[i].col >= 4'(`BOARD_COLS) || piece[i].row >= 5'(`BOARD_ROWS))
				in_board = 1'b0;
	end

	state_legal: assert property (@(posedge clk) disable iff (!arst_n)
		state inside {st_idle, st_count, st_spawn, st_fall, st_clear, st_fail, st_clean})
		else $error("state holds an illegal encoding");

	// a move or descent may sit outside for one cycle before restore
	piece_inside: assert property (@(posedge clk) disable iff (!arst_n)
		(state == st_fall && $past(state) == st_fall && $stable(piece)) |-> in_board)
		else $error("settled piece lies outside the board");

	lines_hold: assert property (@(posedge clk) disable iff (!arst_n)
		($past(state) != st_idle) |-> lines >= $past(lines))
		else $error("line counter went down outside a start press");

	count_down: assert property (@(posedge clk) disable iff (!arst_n)
		(state == st_count && $past(state) == st_count) |-> countdown <= $past(countdown))
		else $error("countdown rose during the count state");

endmodule

// File: sim/tetris_tb.sv
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module tetris_tb import tetris_pkg::*; ();

	localparam int TABLE_ROWS = 12;
	localparam int EXTRA      = 40;   // centre drops until the stack blocks
	localparam int FRAME_CYC  = 40;
	localparam longint LIMIT_NS = longint'(TABLE_ROWS + EXTRA) * 60 * FRAME_CYC * 8
		+ longint'(4 * `COUNT_FRAMES) * FRAME_CYC * 8 * 2;

	logic        clk = 1'b0;
	logic        arst_n = 1'b0;
	logic        frame_tick = 1'b0;
	logic        key_left = 1'b0;
	logic        key_right = 1'b0;
	logic        key_drop = 1'b0;
	logic [4:0]  board_row_sel = 5'd0;
	game_state_e state;
	logic [1:0]  countdown;
	piece_t      piece;
	piece_kind_e next_kind;
	row_bits_t   board_row;
	logic [9:0]  lines;
	logic [5:0]  level;

	// column shift and drop flag per piece
	int shift_tab [TABLE_ROWS] = '{-5, 5, -2, 3, 0, -4, 4, -1, 2, -3, 1, 0};
	bit drop_tab  [TABLE_ROWS] = '{1, 1, 0, 1, 1, 0, 1, 1, 0, 1, 1, 1};

	row_bits_t   shadow [`BOARD_ROWS];
	piece_t      cur;
	int          fall_cnt;
	logic [9:0]  exp_lines;
	logic [5:0]  exp_level;
	int          errors;
	int          test_errs;
	int          tests;
	bit          ended;
	piece_kind_e spawn_kind;
	game_state_e prev_state = st_idle;

	tetris_top dut (.*);

	bind tetris_top tetris_tb_sva sva (.*);

	always #4 clk = ~clk;

	initial begin
		#(LIMIT_NS * 1ns);
		$display("watchdog expired before the tests finished");
		$display("sim failed");
		$finish;
	end

	// kind offered while the spawn cycle runs
	always @(posedge clk) begin
		#1;
		if (state == st_spawn && prev_state != st_spawn)
			spawn_kind = next_kind;
		prev_state = state;
	end

	task automatic cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		$display("[FAIL] %s got=%h exp=%h", name, got, exp);
		errors++;
		test_errs++;
	endtask

	task automatic check_state(input string name, input game_state_e got, input game_state_e exp);
		if (got !== exp)
			fail_value(name, 64'(got), 64'(exp));
	endtask

	task automatic check_row(input string name, input row_bits_t got, input row_bits_t exp);
		if (got !== exp)
			fail_value(name, 64'(got), 64'(exp));
	endtask

	task automatic check_count(input string name, input logic [9:0] got, input logic [9:0] exp);
		if (got !== exp)
			fail_value(name, 64'(got), 64'(exp));
	endtask

	task automatic check_piece(input string name, input piece_t got, input piece_t exp);
		if (got !== exp)
			fail_value(name, 64'(got), 64'(exp));
	endtask

	task automatic end_test(input string name);
		tests++;
		if (test_errs == 0)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, test_errs);
		test_errs = 0;
	endtask

	// ====================
	// board model
	// ====================
	function automatic bit legal(input piece_t p);
		for (int i = 0; i < 4; i++) begin
			if (p[i].col >= 4'(`BOARD_COLS) || p[i].row >= 5'(`BOARD_ROWS))
				return 1'b0;
			if (shadow[p[i].row][p[i].col])
				return 1'b0;
		end
		return 1'b1;
	endfunction

	function automatic piece_t shifted(input piece_t p, input int dc, input int dr);
		piece_t q;
		q = p;
		for (int i = 0; i < 4; i++) begin
			q[i].col = 4'(int'(p[i].col) + dc);
			q[i].row = 5'(int'(p[i].row) + dr);
		end
		return q;
	endfunction

	task automatic lock_piece(input piece_t p);
		bit under [`BOARD_ROWS];
		int n;
		n = 0;
		for (int r = 0; r < `BOARD_ROWS; r++)
			under[r] = 1'b0;
		for (int i = 0; i < 4; i++) begin
			shadow[p[i].row][p[i].col] = 1'b1;
			under[p[i].row] = 1'b1;
		end
		for (int r = 0; r < `BOARD_ROWS; r++) begin
			if (under[r] && &shadow[r]) begin
				shadow[r] = '0;   // in place
				n++;
			end
		end
		exp_lines = exp_lines + 10'(n);
		if (n == 4)
			exp_level = exp_level + 6'd1;
	endtask

	task automatic read_board();
		for (int r = 0; r < `BOARD_ROWS; r++) begin
			board_row_sel = 5'(r);
			cycles(2);
			check_row($sformatf("board_row[%0d]", r), board_row, shadow[r]);
		end
	endtask

	task automatic check_spawn(output bit blocked);
		row_bits_t top;
		row_bits_t bot;
		row_bits_t exp_top;
		row_bits_t exp_bot;
		top = '0;
		bot = '0;
		for (int i = 0; i < 4; i++) begin
			if (piece[i].row == 5'd0)
				top[piece[i].col] = 1'b1;
			else if (piece[i].row == 5'd1)
				bot[piece[i].col] = 1'b1;
			else begin
				$display("spawned cell %0d sits below row 1", i);
				errors++;
				test_errs++;
			end
		end
		if ($countones(top) + $countones(bot) != 4 || ((top | bot) & ~10'h03C) != '0) begin
			$display("spawned piece has repeated cells or leaves columns 2 to 5");
			errors++;
			test_errs++;
		end
		case (spawn_kind)
			pk_t:    begin exp_top = 10'h010; exp_bot = 10'h038; end
			pk_o:    begin exp_top = 10'h018; exp_bot = 10'h018; end
			pk_l:    begin exp_top = 10'h020; exp_bot = 10'h038; end
			pk_j:    begin exp_top = 10'h008; exp_bot = 10'h038; end
			pk_s:    begin exp_top = 10'h030; exp_bot = 10'h018; end
			pk_z:    begin exp_top = 10'h018; exp_bot = 10'h030; end
			pk_i:    begin exp_top = 10'h000; exp_bot = 10'h03C; end
			default: begin exp_top = '1; exp_bot = '1; end   // no legal kind offered
		endcase
		check_row("spawn_top", top, exp_top);
		check_row("spawn_bottom", bot, exp_bot);
		blocked = !legal(piece);
	endtask

	// one frame: optional press, then the tick
	task automatic pulse_frame(input int dir, input bit drop);
		key_drop = drop;
		key_left = dir < 0;
		key_right = dir > 0;
		cycles(1 + $urandom_range(3));
		key_left = 1'b0;
		key_right = 1'b0;
		cycles(2);
		frame_tick = 1'b1;
		cycles(1);
		frame_tick = 1'b0;
		cycles(30);
	endtask

	task automatic play_piece(input int shift, input bit drop_flag, output bit over);
		piece_t moved;
		piece_t down;
		int     left;
		int     dir;
		int     speed;
		bit     drop;
		bit     desc;
		left = shift;
		over = 1'b0;
		for (int n = 0; n < 60; n++) begin
			dir = left > 0 ? 1 : (left < 0 ? -1 : 0);
			left = left - dir;
			drop = drop_flag || n >= 20;   // two gravity steps, then hurry
			pulse_frame(dir, drop);
			moved = shifted(cur, dir, 0);
			if (!legal(moved))
				moved = cur;
			speed = exp_level >= 6'd10 ? 0 : `START_SPEED - int'(exp_level);
			if (fall_cnt < speed)
				fall_cnt++;
			desc = fall_cnt >= speed || drop;
			if (desc)
				fall_cnt = 0;
			down = shifted(moved, 0, 1);
			if (desc && !legal(down)) begin
				lock_piece(moved);
				key_drop = 1'b0;
				check_count("lines", lines, exp_lines);
				check_count("level", 10'(level), 10'(exp_level));
				read_board();
				check_spawn(over);
				check_state("state", state, over ? st_fail : st_fall);
				cur = piece;
				fall_cnt = 0;
				return;
			end
			cur = desc ? down : moved;
			check_piece("piece", piece, cur);
			check_state("state", state, st_fall);
		end
		$display("piece did not lock within 60 frames");
		errors++;
		test_errs++;
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		int  ticks;
		bit  saw_clean;
		void'($urandom(3414));
		errors = 0;
		test_errs = 0;
		tests = 0;
		exp_lines = 10'd0;
		exp_level = 6'd0;
		for (int r = 0; r < `BOARD_ROWS; r++)
			shadow[r] = '0;
		repeat (5) @(posedge clk);
		#1 arst_n = 1'b1;
		cycles(2);

		check_state("state", state, st_idle);
		check_count("lines", lines, 10'd0);
		check_count("level", 10'(level), 10'd0);
		read_board();
		end_test("reset");

		key_drop = 1'b1;   // start press
		cycles(1);
		key_drop = 1'b0;
		cycles(2);
		ticks = 0;
		while (state == st_count && ticks < 200) begin
			check_count("countdown", 10'(countdown), 10'(3 - ticks / `COUNT_FRAMES));
			pulse_frame(0, 1'b0);
			ticks++;
		end
		check_count("start_ticks", 10'(ticks), 10'(4 * `COUNT_FRAMES));
		check_state("state", state, st_fall);
		check_spawn(ended);
		cur = piece;
		fall_cnt = 0;
		end_test("countdown and spawn");

		for (int i = 0; i < TABLE_ROWS && !ended; i++)
			play_piece(shift_tab[i], drop_tab[i], ended);
		for (int k = 0; k < EXTRA && !ended; k++)
			play_piece(0, 1'b1, ended);
		if (!ended) begin
			$display("stack never blocked a spawn");
			errors++;
			test_errs++;
		end
		end_test("moves, gravity, lock and clear");

		check_state("state", state, st_fail);
		check_count("lines", lines, exp_lines);
		check_count("level", 10'(level), 10'(exp_level));
		key_left = 1'b1;
		cycles(1);
		key_left = 1'b0;
		saw_clean = 1'b0;
		for (int c = 0; c < 3 * `BOARD_ROWS && state != st_idle; c++) begin
			if (state == st_clean)
				saw_clean = 1'b1;
			cycles(1);
		end
		if (!saw_clean) begin
			$display("game never passed through the clean state");
			errors++;
			test_errs++;
		end
		check_state("state", state, st_idle);
		for (int r = 0; r < `BOARD_ROWS; r++)
			shadow[r] = '0;
		read_board();
		end_test("fail and clean");

		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
source/tetris_pkg.sv
source/piece_if.sv
source/game_fsm.sv
source/frame_timer.sv
source/piece_unit.sv
source/board_mem.sv
source/tetris_top.sv
sim/tetris_tb_sva.sv
sim/tetris_tb.sv

// File: Bender.yml
package:
  name: tetris

export_include_dirs:
  - include

sources:
  - source/tetris_pkg.sv
  - source/piece_if.sv
  - source/game_fsm.sv
  - source/frame_timer.sv
  - source/piece_unit.sv
  - source/board_mem.sv
  - source/tetris_top.sv
  - target: simulation
    files:
      - sim/tetris_tb_sva.sv
      - sim/tetris_tb.sv
